//--- bench/lsu_props.sv
`timescale 1ns/1ps

module lsu_props
    import lsu_types_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      in_valid,
    input logic      wb_allowin,
    input sram_req_t sram,
    input lsu_ctl_t  dec_ctl,
    input lsu_ctl_t  ctl,
    input logic      valid
);

    // --------------------
    // RAM port
    en_needs_accept: assert property (@(posedge clk) disable iff (!rst_n)
        sram.en |=> (valid && ctl == $past(dec_ctl)))
        else $error("RAM enable without an accepted transfer");

    wen_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
        (sram.wen != 4'b0000) |-> sram.en)
        else $error("RAM byte write without an enable");

    // --------------------
    // handshake
    hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (valid && !wb_allowin) |=> (valid && $stable(ctl)))
        else $error("stage contents moved while write-back stalled");

    empty_allows: assert property (@(posedge clk) disable iff (!rst_n)
        (!valid && in_valid) |=> (valid && ctl == $past(dec_ctl)))
        else $error("empty stage refused a request");

endmodule

bind lsu_access lsu_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .wb_allowin (wb_allowin),
    .sram       (sram),
    .dec_ctl    (dec_ctl),
    .ctl        (ctl),
    .valid      (valid)
);

//--- bench/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb
    import lsu_types_pkg::*;
;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int N_FILL       = 64;   // one sw per test word
    localparam int N_RAND       = 400;
    localparam int N_TAIL       = 8;    // no gaps, no stalls
    localparam int N_REQ        = N_FILL + N_RAND + N_TAIL;
    localparam int WATCH_CYCLES = RESET_CYCLES + 4 * N_REQ;

    // one 64-word area seen through three windows
    localparam word_t USEG_AREA  = 32'h0000_0400;
    localparam word_t KSEG0_AREA = 32'h8000_0400;
    localparam word_t KSEG1_AREA = 32'ha000_0400;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    lsu_req_t in_req;
    logic     allowin;
    logic     wb_allowin;
    logic     out_valid;
    wb_t      out_wb;

    logic [31:0] lfsr = 32'd99812;
    word_t       shadow [64];  // what the test area should hold
    wb_t         exp_q [$];

    lsu_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .allowin    (allowin),
        .wb_allowin (wb_allowin),
        .out_valid  (out_valid),
        .out_wb     (out_wb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    // --------------------
    // random source
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;  // x^32+x^22+x^2+x+1
        end
        return s >> 1;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic mem_op_e op_of(input logic [3:0] sel);
        case (sel)
            4'd0: return op_lb;
            4'd1: return op_lbu;
            4'd2: return op_lh;
            4'd3: return op_lhu;
            4'd4: return op_lw;
            4'd5: return op_lwl;
            4'd6: return op_lwr;
            4'd7: return op_sb;
            4'd8: return op_sh;
            4'd9: return op_sw;
            default: return op_none;
        endcase
    endfunction

    // --------------------
    // requests
    task automatic make_fill(input logic [5:0] idx, input word_t pc, output lsu_req_t req);
        logic [31:0] v;
        req         = '0;
        req.mem_op  = op_sw;
        req.wb_src  = wb_alu;
        req.pc      = pc;
        req.link    = pc + 32'd8;
        req.alu_out = USEG_AREA + {24'h0, idx, 2'b00};
        rand_bits(32, v);
        req.store_data = v;
    endtask

    task automatic make_req(input word_t pc, output lsu_req_t req);
        logic [31:0] v;
        logic [31:0] word_idx;
        logic [1:0]  off;
        word_t       base;
        req = '0;
        rand_bits(4, v);
        req.mem_op = op_of(v[3:0]);
        req.pc     = pc;
        req.link   = pc + 32'd8;
        rand_bits(6, word_idx);
        rand_bits(2, v);
        off = v[1:0];
        case (req.mem_op)
            op_lh, op_lhu, op_sh: off[0] = 1'b0;  // halves stay even
            op_lw, op_sw:         off    = 2'b00;
            default: ;
        endcase
        rand_bits(2, v);
        base = v[1] ? (v[0] ? KSEG1_AREA : KSEG0_AREA) : USEG_AREA;
        req.alu_out = base + {word_idx[29:0], off};
        rand_bits(32, v);
        req.store_data = v;
        rand_bits(5, v);
        req.reg_num = v[4:0];
        case (req.mem_op)
            op_none: begin
                rand_bits(1, v);
                req.wb_src = v[0] ? wb_link : wb_alu;
                rand_bits(32, v);
                req.alu_out = v;  // plain ALU result
            end
            op_sb, op_sh, op_sw: begin
                req.wb_src  = wb_alu;
                req.reg_num = '0;
            end
            default: req.wb_src = wb_load;
        endcase
    endtask

    // --------------------
    // reference model
    function automatic wb_t expected_wb(input lsu_req_t req, input word_t mem_word);
        wb_t         wb;
        int          k;
        logic [7:0]  b;
        logic [15:0] h;
        k          = int'(req.alu_out[1:0]);
        b          = 8'(mem_word >> (8 * k));
        h          = 16'(mem_word >> (8 * k));
        wb.reg_num = req.reg_num;
        wb.pc      = req.pc;
        wb.be      = 4'b1111;
        wb.data    = (req.wb_src == wb_link) ? req.link : req.alu_out;
        if (req.wb_src == wb_load) begin
            case (req.mem_op)
                op_lb:  wb.data = {{24{b[7]}}, b};
                op_lbu: wb.data = {24'h0, b};
                op_lh:  wb.data = {{16{h[15]}}, h};
                op_lhu: wb.data = {16'h0, h};
                op_lwl, op_lwr: begin
                    wb.data = '0;
                    wb.be   = '0;
                    for (int i = 0; i < 4; i++) begin
                        // lwl fills the top k+1 bytes, lwr the low 4-k
                        if (req.mem_op == op_lwl && i >= 3 - k) begin
                            wb.be[i]          = 1'b1;
                            wb.data[8*i +: 8] = mem_word[8*(i-3+k) +: 8];
                        end else if (req.mem_op == op_lwr && i <= 3 - k) begin
                            wb.be[i]          = 1'b1;
                            wb.data[8*i +: 8] = mem_word[8*(i+k) +: 8];
                        end
                    end
                end
                default: wb.data = mem_word;
            endcase
        end
        if (req.reg_num == 5'd0) begin
            wb.be = 4'b0000;
        end
        return wb;
    endfunction

    task automatic apply_store(input lsu_req_t req);
        int idx;
        int k;
        idx = int'(req.alu_out[7:2]);  // all three windows land here
        k   = int'(req.alu_out[1:0]);
        case (req.mem_op)
            op_sb:   shadow[idx][8*k +: 8]  = req.store_data[7:0];
            op_sh:   shadow[idx][8*k +: 16] = req.store_data[15:0];
            op_sw:   shadow[idx]            = req.store_data;
            default: ;
        endcase
    endtask

    // --------------------
    // compare
    always @(posedge clk) begin
        wb_t  want;
        logic busy;
        busy = (exp_q.size() != 0);  // one request held in the stage
        if (rst_n) begin
            assert (out_valid == busy)
                else stop_run($sformatf("** Error at %0t: out_valid = %b, expected %b",
                                        $time, out_valid, busy));
            assert (allowin == (!busy || wb_allowin))
                else stop_run($sformatf("** Error at %0t: allowin = %b, expected %b",
                                        $time, allowin, !busy || wb_allowin));
        end
        if (rst_n && out_valid && wb_allowin) begin
            assert (exp_q.size() != 0)
                else stop_run("write-back transfer with no request outstanding");
            want = exp_q.pop_front();
            assert (out_wb.reg_num == want.reg_num)
                else stop_run($sformatf("** Error at %0t: out_wb.reg_num = %0d, expected %0d",
                                        $time, out_wb.reg_num, want.reg_num));
            assert (out_wb.be == want.be)
                else stop_run($sformatf("** Error at %0t: out_wb.be = %b, expected %b",
                                        $time, out_wb.be, want.be));
            assert (out_wb.data == want.data)
                else stop_run($sformatf("** Error at %0t: out_wb.data = %h, expected %h",
                                        $time, out_wb.data, want.data));
            assert (out_wb.pc == want.pc)
                else stop_run($sformatf("** Error at %0t: out_wb.pc = %h, expected %h",
                                        $time, out_wb.pc, want.pc));
        end
        if (rst_n && in_valid && allowin) begin
            exp_q.push_back(expected_wb(in_req, shadow[in_req.alu_out[7:2]]));
            apply_store(in_req);
        end
    end

    // --------------------
    // stimulus
    initial begin
        lsu_req_t    cur;
        logic        pending;
        logic [31:0] v;
        word_t       pc;
        int          sent;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_req     = '0;
        wb_allowin = 1'b1;
        cur        = '0;
        pending    = 1'b0;
        sent       = 0;
        pc         = 32'h0040_0000;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while (sent < N_REQ) begin
            @(negedge clk);
            if (sent >= N_REQ - N_TAIL) begin
                wb_allowin = 1'b1;
            end else begin
                rand_bits(2, v);
                wb_allowin = (v[1:0] != 2'b00);  // stall one cycle in four
            end
            if (!pending) begin
                if (sent < N_FILL) begin
                    make_fill(sent[5:0], pc, cur);
                    pending = 1'b1;
                end else if (sent >= N_REQ - N_TAIL) begin
                    make_req(pc, cur);
                    pending = 1'b1;
                end else begin
                    rand_bits(2, v);
                    if (v[1:0] != 2'b00) begin  // otherwise a gap
                        make_req(pc, cur);
                        pending = 1'b1;
                    end
                end
                if (pending) begin
                    pc = pc + 32'd4;
                end
            end
            in_valid = pending;
            in_req   = cur;
            @(posedge clk);
            if (in_valid && allowin) begin
                pending = 1'b0;
                sent++;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        assert (out_valid)
            else stop_run("out_valid did not rise one cycle after the last acceptance");
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        if (out_valid || exp_q.size() != 0) begin
            stop_run("stage still busy after the stream drained");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

    initial begin
        #(WATCH_CYCLES * CLK_PERIOD);
        stop_run("watchdog expired before the stream drained");
    end

endmodule

//--- hw/data_ram.sv
`timescale 1ns/1ps

module data_ram
    import lsu_types_pkg::*, lsu_map_pkg::*;
(
    input  logic      clk,
    input  sram_req_t req,
    output word_t     rdata
);

    word_t mem [RAM_WORDS];

    logic [RAM_WORD_BITS-1:0] idx;

    // high address bits ignored, so the array aliases
    assign idx = req.addr[RAM_IDX_MSB:RAM_IDX_LSB];

    // --------------------
    // lane writes
    always_ff @(posedge clk) begin
        if (req.en) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (req.wen[lane]) begin
                    mem[idx][lane*8 +: 8] <= req.wdata[lane*8 +: 8];
                end
            end
        end
    end

    // --------------------
    // registered read
    // rdata only moves on an enable, so a stalled load keeps its word
    always_ff @(posedge clk) begin
        if (req.en) begin
            rdata <= mem[idx];  // old word on a store cycle
        end
    end

endmodule

//--- hw/lsu_access.sv
`timescale 1ns/1ps

module lsu_access
    import lsu_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    output logic      allowin,
    input  logic      wb_allowin,
    input  sram_req_t dec_sram,
    input  lsu_ctl_t  dec_ctl,
    output sram_req_t sram,
    output lsu_ctl_t  ctl,
    output logic      valid
);

    logic accept;  // transfer from execute this edge

    // --------------------
    // handshake
    // the stage takes a new request when it is empty or when write-back
    // drains the current one on the same edge
    assign allowin = !valid || wb_allowin;
    assign accept  = in_valid && allowin;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;  // fill, refill or drain
        end
    end

    // --------------------
    // stage register
    always_ff @(posedge clk) begin
        if (accept) begin
            ctl <= dec_ctl;
        end
    end

    // --------------------
    // RAM request
    always_comb begin
        sram       = dec_sram;
        sram.en    = dec_sram.en && accept;      // no access on stall
        sram.wen   = dec_sram.wen & {4{accept}}; // refused store writes nothing
    end

endmodule

//--- hw/lsu_decode.sv
`timescale 1ns/1ps

module lsu_decode
    import lsu_types_pkg::*, lsu_map_pkg::*;
(
    input  lsu_req_t  in_req,
    output sram_req_t sram_req,
    output lsu_ctl_t  ctl
);

    word_t     vaddr;
    word_t     paddr;
    logic      in_seg;      // vaddr inside kseg0/kseg1
    byte_off_t off;
    logic      is_mem;

    assign vaddr = in_req.alu_out;
    assign off   = vaddr[1:0];

    // --------------------
    // fixed mapping
    assign in_seg = (vaddr >= KSEG0_BASE) && (vaddr <= KSEG1_END);
    assign paddr  = in_seg ? {{SEG_STRIP_BITS{1'b0}}, vaddr[31-SEG_STRIP_BITS:0]}
                           : vaddr;

    assign is_mem = (in_req.mem_op != op_none);

    // --------------------
    // store lanes
    always_comb begin
        sram_req.en    = is_mem;  // request intent, gated later
        sram_req.addr  = paddr;
        sram_req.wen   = '0;
        sram_req.wdata = in_req.store_data;
        case (in_req.mem_op)
            op_sb: begin
                sram_req.wen   = byte_en_t'(4'b0001 << off);
                sram_req.wdata = {4{in_req.store_data[7:0]}};  // byte in every lane
            end
            op_sh: begin
                sram_req.wen   = off[1] ? 4'b1100 : 4'b0011;
                sram_req.wdata = {2{in_req.store_data[15:0]}};
            end
            op_sw: begin
                sram_req.wen   = 4'b1111;
            end
            default: begin
                sram_req.wen   = '0;  // loads and non-memory ops
            end
        endcase
    end

    // --------------------
    // control carried to the result side
    always_comb begin
        ctl.mem_op   = in_req.mem_op;
        ctl.wb_src   = in_req.wb_src;
        ctl.reg_num  = in_req.reg_num;
        ctl.pc       = in_req.pc;
        ctl.alu_out  = in_req.alu_out;
        ctl.link     = in_req.link;
        ctl.byte_off = off;  // picks lanes after the RAM read
    end

endmodule

//--- hw/lsu_map_pkg.sv
package lsu_map_pkg;

    // --------------------
    // fixed address windows
    // kseg0 starts at 0x8000_0000 and kseg1 ends at 0xbfff_ffff, both map
    // straight onto physical memory once the top bits are dropped
    localparam logic [31:0] KSEG0_BASE = 32'h8000_0000;
    localparam logic [31:0] KSEG1_END  = 32'hbfff_ffff;

    localparam int SEG_STRIP_BITS = 3;  // top bits cleared in window

    // --------------------
    // data RAM geometry
    localparam int RAM_WORD_BITS = 10;  // word index width
    localparam int RAM_WORDS     = 1 << RAM_WORD_BITS;  // aliases above this

    // index field within a byte address
    localparam int RAM_IDX_LSB = 2;
    localparam int RAM_IDX_MSB = RAM_WORD_BITS + RAM_IDX_LSB - 1;

endpackage

//--- hw/lsu_result.sv
`timescale 1ns/1ps

module lsu_result
    import lsu_types_pkg::*;
(
    input  logic     valid,
    input  lsu_ctl_t ctl,
    input  word_t    rdata,
    output logic     out_valid,
    output wb_t      out_wb
);

    byte_off_t  off;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    word_t      load_data;
    byte_en_t   load_be;
    word_t      wb_data;
    byte_en_t   wb_be;

    assign off = ctl.byte_off;

    // --------------------
    // lane extraction
    assign ld_byte = rdata[{off, 3'b000} +: 8];
    assign ld_half = off[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        load_be   = 4'b1111;
        load_data = rdata;
        case (ctl.mem_op)
            op_lb:  load_data = {{24{ld_byte[7]}}, ld_byte};
            op_lbu: load_data = {24'b0, ld_byte};
            op_lh:  load_data = {{16{ld_half[15]}}, ld_half};
            op_lhu: load_data = {16'b0, ld_half};
            op_lw:  load_data = rdata;
            op_lwl: begin
                // low k+1 memory bytes land in the top of the register
                load_data = rdata << {~off, 3'b000};
                load_be   = byte_en_t'(4'b1111 << ~off);
            end
            op_lwr: begin
                // memory bytes k..3 land in the bottom of the register
                load_data = rdata >> {off, 3'b000};
                load_be   = byte_en_t'(4'b1111 >> off);
            end
            default: begin
                load_data = rdata;
                load_be   = 4'b1111;
            end
        endcase
    end

    // --------------------
    // write-back select
    always_comb begin
        case (ctl.wb_src)
            wb_load: begin
                wb_data = load_data;
                wb_be   = load_be;   // partial only for lwl/lwr
            end
            wb_link: begin
                wb_data = ctl.link;
                wb_be   = 4'b1111;
            end
            default: begin
                wb_data = ctl.alu_out;
                wb_be   = 4'b1111;
            end
        endcase
    end

    assign out_valid      = valid;
    assign out_wb.reg_num = ctl.reg_num;
    assign out_wb.be      = (ctl.reg_num == '0) ? 4'b0000 : wb_be;  // r0 stays zero
    assign out_wb.data    = wb_data;
    assign out_wb.pc      = ctl.pc;

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/1ps

module lsu_top
    import lsu_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  lsu_req_t in_req,
    output logic     allowin,
    input  logic     wb_allowin,
    output logic     out_valid,
    output wb_t      out_wb
);

    sram_req_t dec_sram;  // decoded, not yet gated
    lsu_ctl_t  dec_ctl;
    sram_req_t sram;      // gated by acceptance
    lsu_ctl_t  ctl;       // registered stage contents
    logic      valid;
    word_t     rdata;

    lsu_decode u_decode (
        .in_req   (in_req),
        .sram_req (dec_sram),
        .ctl      (dec_ctl)
    );

    lsu_access u_access (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .allowin    (allowin),
        .wb_allowin (wb_allowin),
        .dec_sram   (dec_sram),
        .dec_ctl    (dec_ctl),
        .sram       (sram),
        .ctl        (ctl),
        .valid      (valid)
    );

    data_ram u_ram (
        .clk   (clk),
        .req   (sram),
        .rdata (rdata)
    );

    lsu_result u_result (
        .valid     (valid),
        .ctl       (ctl),
        .rdata     (rdata),
        .out_valid (out_valid),
        .out_wb    (out_wb)
    );

endmodule

//--- hw/lsu_types_pkg.sv
package lsu_types_pkg;

    // --------------------
    // widths with a meaning
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;   // reg 0 never written
    typedef logic [3:0]  byte_en_t;   // one bit per byte lane
    typedef logic [1:0]  byte_off_t;  // byte within a word

    typedef enum logic [3:0] {
        op_none, op_lb, op_lbu, op_lh, op_lhu, op_lw,
        op_lwl, op_lwr, op_sb, op_sh, op_sw
    } mem_op_e;

    typedef enum logic [1:0] {
        wb_alu, wb_load, wb_link
    } wb_src_e;

    // --------------------
    // stage structs
    typedef struct packed {
        mem_op_e  mem_op;
        wb_src_e  wb_src;
        reg_idx_t reg_num;     // destination register
        word_t    pc;
        word_t    alu_out;     // vaddr for memory ops
        word_t    store_data;
        word_t    link;        // return address
    } lsu_req_t;

    typedef struct packed {
        mem_op_e   mem_op;
        wb_src_e   wb_src;
        reg_idx_t  reg_num;
        word_t     pc;
        word_t     alu_out;
        word_t     link;
        byte_off_t byte_off;
    } lsu_ctl_t;

    typedef struct packed {
        logic     en;
        byte_en_t wen;
        word_t    addr;        // physical byte address
        word_t    wdata;
    } sram_req_t;

    typedef struct packed {
        reg_idx_t reg_num;
        byte_en_t be;
        word_t    data;
        word_t    pc;
    } wb_t;

endpackage

//--- list.f
hw/lsu_types_pkg.sv
hw/lsu_map_pkg.sv
hw/lsu_decode.sv
hw/lsu_access.sv
hw/lsu_result.sv
hw/data_ram.sv
hw/lsu_top.sv
bench/lsu_props.sv
bench/lsu_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the memory stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module lsu_tb \
    -Mdir obj_dir -o lsu_sim \
    -f list.f \
    && ./obj_dir/lsu_sim \
    || { echo "simulation did not pass" >&2; exit 1; }
